// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

  ////////////////////
  // address split
  ////////////////////

  // host line address, set index in the low bits and tag above it
  localparam int addr_w  = 14;                  // full line address
  localparam int index_w = 5;                   // addr[4:0] selects the set
  localparam int tag_w   = 9;                   // addr[13:5] is kept as tag

  ////////////////////
  // array geometry
  ////////////////////

  localparam int sets   = 32;                   // 2**index_w sets
  localparam int data_w = 64;                   // one full line per way

  ////////////////////
  // way select
  ////////////////////

  // lru bit, accessed way and victim all use this encoding
  localparam logic way_lo = 1'b0;               // way 0
  localparam logic way_hi = 1'b1;               // way 1

endpackage

`default_nettype wire

// File: verilog/cache_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_if;

  ////////////////////
  // accepted request
  ////////////////////
  logic                                start;     // one-cycle pulse per request
  logic                                we;        // 1 writes the line
  logic                                toggle;    // move lru off the used way
  logic                                wdirty;    // dirty bit stored on write
  logic [cache_pkg::index_w-1:0]       index;     // set being accessed
  logic [cache_pkg::tag_w-1:0]         tag;       // tag to compare and store
  logic [cache_pkg::data_w-1:0]        wr_data;   // line stored on write

  ////////////////////
  // pre-access set
  ////////////////////
  logic                                done;      // one-cycle pulse, set is valid
  logic [1:0]                          valid;     // per-way valid
  logic [1:0]                          dirty;     // per-way dirty
  logic [1:0][cache_pkg::tag_w-1:0]    way_tag;   // per-way stored tag
  logic [1:0][cache_pkg::data_w-1:0]   way_data;  // per-way stored line
  logic                                lru;       // victim way of the set
  logic [1:0]                          match;     // valid and tag equal

  modport dec (output start, we, toggle, wdirty, index, tag, wr_data);

  modport exe (input start, we, toggle, wdirty, index, tag, wr_data,
               output done, valid, dirty, way_tag, way_data, lru, match);

  modport res (input done, valid, dirty, way_tag, way_data, lru, match);

endinterface

`default_nettype wire

// File: verilog/req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module req_decode (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            req,      // host request, four-phase
  input logic                            ack,      // response flag from result stage
  input logic                            we,
  input logic                            toggle,
  input logic                            wdirty,
  input logic [cache_pkg::addr_w-1:0]    addr,
  input logic [cache_pkg::data_w-1:0]    wr_data,
  cache_if.dec                           bus
);

  logic busy;                                     // request in flight
  logic accept;                                   // take the request this cycle

  ////////////////////
  // handshake
  ////////////////////

  // req must be high, previous ack gone and nothing pending
  assign accept = req && !ack && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      bus.start <= 1'b0;
    end else begin
      bus.start <= accept;                        // single pulse, accept is one cycle
      if (accept) begin
        busy <= 1'b1;                             // hold off until ack seen
      end else if (ack) begin
        busy <= 1'b0;                             // response is out, rearm
      end
    end
  end

  ////////////////////
  // request fields
  ////////////////////

  // fields only load on accept so they stay put while the request runs
  always_ff @(posedge clk) begin
    if (accept) begin
      bus.we      <= we;
      bus.toggle  <= toggle;
      bus.wdirty  <= wdirty;
      bus.index   <= addr[cache_pkg::index_w-1:0];               // low bits pick the set
      bus.tag     <= addr[cache_pkg::addr_w-1:cache_pkg::index_w]; // rest is the tag
      bus.wr_data <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/way_array.sv
`timescale 1ns/1ps
`default_nettype none

module way_array (
  input logic  clk,
  input logic  rst_n,
  cache_if.exe bus
);

  ////////////////////
  // storage
  ////////////////////

  // control bits, cleared on reset
  logic [cache_pkg::sets-1:0][1:0]    valid_q;    // per set, per way
  logic [cache_pkg::sets-1:0][1:0]    dirty_q;    // per set, per way
  logic [cache_pkg::sets-1:0]         lru_q;      // victim way per set

  // line payload
  logic [1:0][cache_pkg::tag_w-1:0]   tag_mem  [cache_pkg::sets];
  logic [1:0][cache_pkg::data_w-1:0]  data_mem [cache_pkg::sets];

  ////////////////////
  // set lookup
  ////////////////////

  logic [1:0]                         set_valid;  // valid bits of addressed set
  logic [1:0]                         set_dirty;  // dirty bits of addressed set
  logic [1:0][cache_pkg::tag_w-1:0]   set_tag;    // stored tags of addressed set
  logic [1:0][cache_pkg::data_w-1:0]  set_data;   // stored lines of addressed set
  logic                               set_lru;    // current victim
  logic [1:0]                         set_match;  // valid and tag hit, per way
  logic                               acc_way;    // way read or written by this access

  always_comb begin
    set_valid = valid_q[bus.index];
    set_dirty = dirty_q[bus.index];
    set_tag   = tag_mem[bus.index];
    set_data  = data_mem[bus.index];
    set_lru   = lru_q[bus.index];

    // a way only matches when it holds a valid line
    set_match[cache_pkg::way_lo] = set_valid[cache_pkg::way_lo] &&
                                   (set_tag[cache_pkg::way_lo] == bus.tag);
    set_match[cache_pkg::way_hi] = set_valid[cache_pkg::way_hi] &&
                                   (set_tag[cache_pkg::way_hi] == bus.tag);

    // matching way first, otherwise the lru victim
    if (set_match[cache_pkg::way_hi]) begin
      acc_way = cache_pkg::way_hi;
    end else if (set_match[cache_pkg::way_lo]) begin
      acc_way = cache_pkg::way_lo;
    end else begin
      acc_way = set_lru;
    end
  end

  ////////////////////
  // control update
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= '0;                             // all ways empty
      dirty_q  <= '0;
      lru_q    <= '0;                             // way 0 is first victim
      bus.done <= 1'b0;
    end else begin
      bus.done <= bus.start;                      // set captured below on same edge
      if (bus.start && bus.we) begin
        valid_q[bus.index][acc_way] <= 1'b1;
        dirty_q[bus.index][acc_way] <= bus.wdirty;
      end
      if (bus.start && bus.toggle) begin
        lru_q[bus.index] <= ~acc_way;             // next victim is the other way
      end
    end
  end

  ////////////////////
  // capture and write
  ////////////////////

  // capture sees the set before this edge's write lands
  always_ff @(posedge clk) begin
    if (bus.start) begin
      bus.valid    <= set_valid;
      bus.dirty    <= set_dirty;
      bus.way_tag  <= set_tag;
      bus.way_data <= set_data;
      bus.lru      <= set_lru;
      bus.match    <= set_match;
      if (bus.we) begin
        tag_mem[bus.index][acc_way]  <= bus.tag;      // new owner of the way
        data_mem[bus.index][acc_way] <= bus.wr_data;  // whole line replaced
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/resp_select.sv
`timescale 1ns/1ps
`default_nettype none

module resp_select (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req,       // host request, ack falls once it drops
  output logic                         ack,
  output logic                         hit,
  output logic                         dirty,     // selected line needs writeback
  output logic [cache_pkg::data_w-1:0] rd_data,
  output logic [cache_pkg::tag_w-1:0]  tag_out,   // victim tag on a miss
  cache_if.res                         bus
);

  logic hit_any;                                  // either way matched
  logic sel_way;                                  // way reported to host

  ////////////////////
  // way select
  ////////////////////

  always_comb begin
    hit_any = |bus.match;
    if (bus.match[cache_pkg::way_hi]) begin
      sel_way = cache_pkg::way_hi;
    end else if (bus.match[cache_pkg::way_lo]) begin
      sel_way = cache_pkg::way_lo;
    end else begin
      sel_way = bus.lru;                          // miss reports the victim
    end
  end

  ////////////////////
  // response
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      hit     <= 1'b0;
      dirty   <= 1'b0;
      rd_data <= '0;
      tag_out <= '0;
    end else if (bus.done) begin
      ack     <= 1'b1;
      hit     <= hit_any;
      dirty   <= bus.valid[sel_way] & bus.dirty[sel_way];  // empty way is never dirty
      rd_data <= bus.way_data[sel_way];
      tag_out <= bus.way_tag[sel_way];
    end else if (!req) begin
      ack <= 1'b0;                                // response held until host lets go
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req,
  input  logic                         we,
  input  logic                         toggle,
  input  logic                         wdirty,
  input  logic [cache_pkg::addr_w-1:0] addr,
  input  logic [cache_pkg::data_w-1:0] wr_data,
  output logic                         ack,
  output logic                         hit,
  output logic                         dirty,
  output logic [cache_pkg::data_w-1:0] rd_data,
  output logic [cache_pkg::tag_w-1:0]  tag_out
);

  cache_if bus ();                                // stage to stage bundle

  ////////////////////
  // stages
  ////////////////////

  // decode, request in and one start pulse out
  req_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),                               // rearms decode after response
    .we      (we),
    .toggle  (toggle),
    .wdirty  (wdirty),
    .addr    (addr),
    .wr_data (wr_data),
    .bus     (bus.dec)
  );

  // execute, tag compare and set update
  way_array u_ways (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.exe)
  );

  // result, hit or victim way to host
  resp_select u_resp (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .hit     (hit),
    .dirty   (dirty),
    .rd_data (rd_data),
    .tag_out (tag_out),
    .bus     (bus.res)
  );

endmodule

`default_nettype wire

// File: verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam int directed_ops  = 48;              // reset sweep plus directed sequences
  localparam int random_ops    = 300;
  localparam int num_ops       = directed_ops + random_ops;
  localparam int timeout_limit = num_ops * 8 + 50; // about 6 cycles per handshake

  logic                         clk;
  logic                         rst_n;
  logic                         req;
  logic                         we;
  logic                         toggle;
  logic                         wdirty;
  logic [cache_pkg::addr_w-1:0] addr;
  logic [cache_pkg::data_w-1:0] wr_data;
  logic                         ack;
  logic                         hit;
  logic                         dirty;
  logic [cache_pkg::data_w-1:0] rd_data;
  logic [cache_pkg::tag_w-1:0]  tag_out;

  integer seed = 32'h0e87893f;                    // fixed seed for $random
  int     cycles;                                 // clock edges since start

  // last response seen by the directed checks
  logic                         last_hit;
  logic                         last_dirty;
  logic [cache_pkg::tag_w-1:0]  last_tag;
  logic [cache_pkg::data_w-1:0] last_data;

  ////////////////////
  // reference model
  ////////////////////
  logic [1:0]                        m_valid [cache_pkg::sets];
  logic [1:0]                        m_dirty [cache_pkg::sets];
  logic [1:0][cache_pkg::tag_w-1:0]  m_tag   [cache_pkg::sets];
  logic [1:0][cache_pkg::data_w-1:0] m_data  [cache_pkg::sets];
  logic                              m_lru   [cache_pkg::sets];  // victim way

  cache_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .we      (we),
    .toggle  (toggle),
    .wdirty  (wdirty),
    .addr    (addr),
    .wr_data (wr_data),
    .ack     (ack),
    .hit     (hit),
    .dirty   (dirty),
    .rd_data (rd_data),
    .tag_out (tag_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                       // 100 ns period
  end

  // a stuck handshake ends the run here
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= timeout_limit) begin
        $display("timeout: handshake did not complete");
        $display(">>> FAIL");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  function automatic logic [cache_pkg::addr_w-1:0] line_addr(
    input logic [cache_pkg::tag_w-1:0]   tg,
    input logic [cache_pkg::index_w-1:0] set
  );
    return {tg, set};                             // tag above the set index
  endfunction

  // expected response from the pre-access set and the set update after it
  function automatic void predict(
    input  logic                         a_we,
    input  logic                         a_toggle,
    input  logic                         a_wdirty,
    input  logic [cache_pkg::addr_w-1:0] a_addr,
    input  logic [cache_pkg::data_w-1:0] a_data,
    output logic                         e_hit,
    output logic                         e_dirty,
    output logic [cache_pkg::data_w-1:0] e_data,
    output logic [cache_pkg::tag_w-1:0]  e_tag,
    output logic                         e_known
  );
    logic [cache_pkg::index_w-1:0] idx;
    logic [cache_pkg::tag_w-1:0]   tg;
    logic [1:0]                    m;
    logic                          way;
    idx  = a_addr[cache_pkg::index_w-1:0];
    tg   = a_addr[cache_pkg::addr_w-1:cache_pkg::index_w];
    m[0] = m_valid[idx][0] && (m_tag[idx][0] == tg);
    m[1] = m_valid[idx][1] && (m_tag[idx][1] == tg);
    e_hit = m[0] || m[1];
    if (m[0]) way = 1'b0;                         // hit uses matching way
    else if (m[1]) way = 1'b1;
    else way = m_lru[idx];                        // miss names the victim
    e_dirty = m_valid[idx][way] && m_dirty[idx][way];
    e_data  = m_data[idx][way];
    e_tag   = m_tag[idx][way];
    e_known = m_valid[idx][way];                  // empty way holds no defined line
    if (a_we) begin
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = a_wdirty;
      m_tag[idx][way]   = tg;
      m_data[idx][way]  = a_data;
    end
    if (a_toggle) m_lru[idx] = ~way;              // point away from the used way
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one four-phase transaction with the response compared while ack is high
  task automatic handshake(
    input logic                         a_we,
    input logic                         a_toggle,
    input logic                         a_wdirty,
    input logic [cache_pkg::addr_w-1:0] a_addr,
    input logic [cache_pkg::data_w-1:0] a_data
  );
    logic                         e_hit;
    logic                         e_dirty;
    logic                         e_known;
    logic [cache_pkg::data_w-1:0] e_data;
    logic [cache_pkg::tag_w-1:0]  e_tag;
    predict(a_we, a_toggle, a_wdirty, a_addr, a_data, e_hit, e_dirty, e_data, e_tag, e_known);
    @(negedge clk);
    we      = a_we;
    toggle  = a_toggle;
    wdirty  = a_wdirty;
    addr    = a_addr;
    wr_data = a_data;
    req     = 1'b1;                               // inputs stable with req
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    check(64'(hit), 64'(e_hit), "hit");
    check(64'(dirty), 64'(e_dirty), "dirty");
    if (e_known) begin
      check(rd_data, e_data, "rd_data");
      check(64'(tag_out), 64'(e_tag), "tag_out");
    end
    last_hit   = hit;
    last_dirty = dirty;
    last_tag   = tag_out;
    last_data  = rd_data;
    req = 1'b0;
    @(negedge clk);
    while (ack !== 1'b0) @(negedge clk);          // ack must follow req down
  endtask

  initial begin
    logic [31:0]                  rnd;
    logic [cache_pkg::data_w-1:0] rdata;
    rst_n    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    toggle   = 1'b0;
    wdirty   = 1'b0;
    addr     = '0;
    wr_data  = '0;
    for (int s = 0; s < cache_pkg::sets; s++) begin
      m_valid[s] = '0;
      m_dirty[s] = '0;
      m_lru[s]   = 1'b0;
    end
    repeat (2) @(negedge clk);                    // two reset cycles
    rst_n = 1'b1;

    ////////////////////
    // empty cache
    ////////////////////
    for (int s = 0; s < cache_pkg::sets; s++) begin
      handshake(1'b0, 1'b0, 1'b0, line_addr(9'h000, s[4:0]), '0);
      check(64'(last_hit), 64'd0, "hit after reset");
      check(64'(last_dirty), 64'd0, "dirty after reset");
    end

    // dirty write then read back in set 1
    handshake(1'b1, 1'b1, 1'b1, line_addr(9'h055, 5'd1), 64'hdead_beef_0123_4567);
    check(64'(last_hit), 64'd0, "write to empty set");
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h055, 5'd1), '0);
    check(64'(last_hit), 64'd1, "read after write");
    check(64'(last_dirty), 64'd1, "dirty after write");
    check(last_data, 64'hdead_beef_0123_4567, "data after write");

    ////////////////////
    // both ways of set 3
    ////////////////////
    handshake(1'b1, 1'b1, 1'b1, line_addr(9'h011, 5'd3), 64'h1111_aaaa_1111_aaaa);
    handshake(1'b1, 1'b1, 1'b0, line_addr(9'h022, 5'd3), 64'h2222_bbbb_2222_bbbb);
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h011, 5'd3), '0);
    check(64'(last_hit), 64'd1, "first tag in set 3");
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h022, 5'd3), '0);
    check(64'(last_hit), 64'd1, "second tag in set 3");

    // third tag misses on the lru way and the toggled read moves lru to way 1
    handshake(1'b0, 1'b1, 1'b0, line_addr(9'h033, 5'd3), '0);
    check(64'(last_hit), 64'd0, "third tag read");
    check(64'(last_tag), 64'h011, "victim tag");
    check(last_data, 64'h1111_aaaa_1111_aaaa, "victim data");
    check(64'(last_dirty), 64'd1, "victim dirty");
    handshake(1'b1, 1'b1, 1'b0, line_addr(9'h033, 5'd3), 64'h3333_cccc_3333_cccc);
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h022, 5'd3), '0);
    check(64'(last_hit), 64'd0, "evicted tag");
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h033, 5'd3), '0);
    check(64'(last_hit), 64'd1, "replacing tag");

    ////////////////////
    // no toggle in set 7
    ////////////////////
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h101, 5'd7), '0);
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h101, 5'd7), '0);
    handshake(1'b1, 1'b0, 1'b1, line_addr(9'h102, 5'd7), 64'h4444_dddd_4444_dddd);
    handshake(1'b1, 1'b0, 1'b0, line_addr(9'h103, 5'd7), 64'h5555_eeee_5555_eeee);
    check(64'(last_tag), 64'h102, "victim kept on way 0");   // second write lands on way 0 too
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h104, 5'd7), '0);
    check(64'(last_tag), 64'h103, "repeated miss victim");
    handshake(1'b0, 1'b0, 1'b0, line_addr(9'h105, 5'd7), '0);
    check(64'(last_tag), 64'h103, "repeated miss victim");

    ////////////////////
    // random traffic
    ////////////////////
    for (int i = 0; i < random_ops; i++) begin
      rnd   = $random(seed);
      rdata = {$random(seed), $random(seed)};
      // four tags over four sets forces evictions
      handshake(rnd[0], rnd[1], rnd[2], line_addr({7'd0, rnd[5:4]}, {3'd0, rnd[7:6]}), rdata);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: two_way_cache.f
verilog/cache_pkg.sv
verilog/cache_if.sv
verilog/req_decode.sv
verilog/way_array.sv
verilog/resp_select.sv
verilog/cache_top.sv
verification/cache_tb.sv

// File: Makefile
# Verilator build and run for two_way_cache

VERILATOR ?= verilator
TOP       ?= cache_tb
FLIST     ?= two_way_cache.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST LOG OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
